/* hw/mmu_addr_pkg.sv */
`default_nettype none

package mmu_addr_pkg;

    ////////////////////////////////
    // Address geometry
    ////////////////////////////////

    parameter int VADDR_BITS = 32;
    parameter int PADDR_BITS = 32;

    // 4 KiB pages
    parameter int PAGE_BITS = 12;
    parameter int VPN_BITS  = VADDR_BITS - PAGE_BITS;
    parameter int PPN_BITS  = PADDR_BITS - PAGE_BITS;

    parameter int LEN_BITS = 16;

    ////////////////////////////////
    // Request descriptor
    ////////////////////////////////

    // Virtual address on the way in, physical address on the way out
    typedef struct packed {
        logic [VADDR_BITS-1:0] addr;
        logic [LEN_BITS-1:0]   len;
        logic                  wr;
    } mmu_req_t;

endpackage

`default_nettype wire

/* hw/mmu_cnfg_pkg.sv */
`default_nettype none

package mmu_cnfg_pkg;

    import mmu_addr_pkg::*;

    ////////////////////////////////
    // Configuration opcodes
    ////////////////////////////////

    typedef enum logic [1:0] {
        CNFG_ENTRY   = 2'd0,
        CNFG_RESOLVE = 2'd1,
        CNFG_FLUSH   = 2'd2
    } cnfg_op_e;

    parameter int CNFG_BITS = 48;
    parameter int IDX_BITS  = 4;

    // Padding keeps both views the same width
    parameter int ENTRY_PAD_BITS = CNFG_BITS - 2 - IDX_BITS - 1 - VPN_BITS - PPN_BITS;
    parameter int CTRL_PAD_BITS  = CNFG_BITS - 2 - 1;

    ////////////////////////////////
    // Configuration word views
    ////////////////////////////////

    typedef struct packed {
        cnfg_op_e                  op;
        logic [IDX_BITS-1:0]       idx;
        logic                      valid;
        logic [VPN_BITS-1:0]       vpn;
        logic [PPN_BITS-1:0]       ppn;
        logic [ENTRY_PAD_BITS-1:0] pad;
    } cnfg_entry_t;

    // retry: 1 repeats the lookup, 0 drops the request
    typedef struct packed {
        cnfg_op_e                 op;
        logic                     retry;
        logic [CTRL_PAD_BITS-1:0] pad;
    } cnfg_ctrl_t;

    // Op occupies the top bits in both views
    typedef union packed {
        cnfg_entry_t entry;
        cnfg_ctrl_t  ctrl;
    } cnfg_word_u;

endpackage

`default_nettype wire

/* hw/mmu_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mmu_req_if
    import mmu_addr_pkg::*;
#(
    parameter int N_REGIONS = 4
) ();

    logic                         valid;
    logic                         ready;
    mmu_req_t                     req;
    logic [$clog2(N_REGIONS)-1:0] region;

    // Producer side
    modport source (
        output valid,
        output req,
        output region,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid,
        input  req,
        input  region,
        output ready
    );

endinterface

`default_nettype wire

/* hw/mmu_req_dispatch.sv */
`timescale 1ns/10ps
`default_nettype none

module mmu_req_dispatch
    import mmu_addr_pkg::*;
#(
    parameter int N_REGIONS = 4
) (
    input  logic                         req_valid,
    input  mmu_req_t                     req,
    input  logic [$clog2(N_REGIONS)-1:0] req_region,
    output logic                         req_ready,

    mmu_req_if.source                    reg_out [N_REGIONS]
);

    localparam int REGION_BITS = $clog2(N_REGIONS);

    ////////////////////////////////
    // Region steering
    ////////////////////////////////

    logic [N_REGIONS-1:0] region_sel;
    logic [N_REGIONS-1:0] region_ready;

    for (genvar i = 0; i < N_REGIONS; i++) begin : g_region

        // One-hot decode of the target region
        assign region_sel[i] = (req_region == REGION_BITS'(i));

        assign reg_out[i].valid  = req_valid && region_sel[i];
        assign reg_out[i].req    = req;
        assign reg_out[i].region = req_region;

        assign region_ready[i] = reg_out[i].ready;

    end

    // Only the addressed region can accept
    assign req_ready = region_ready[req_region];

endmodule

`default_nettype wire

/* hw/mmu_region.sv */
`timescale 1ns/10ps
`default_nettype none

module mmu_region
    import mmu_addr_pkg::*;
    import mmu_cnfg_pkg::*;
#(
    parameter int N_REGIONS   = 4,
    parameter int REGION_ID   = 0,
    parameter int TLB_ENTRIES = 8
) (
    input  logic                         aclk,
    input  logic                         rst_n,

    input  logic                         cnfg_valid,
    input  logic [$clog2(N_REGIONS)-1:0] cnfg_region,
    input  cnfg_word_u                   cnfg_word,

    mmu_req_if.sink                      s_req,
    mmu_req_if.source                    m_req,

    output logic                         pfault_irq,
    output logic [VADDR_BITS-1:0]        pfault_vaddr
);

    localparam int REGION_BITS = $clog2(N_REGIONS);

    ////////////////////////////////
    // State
    ////////////////////////////////

    logic                      tlb_valid [TLB_ENTRIES];
    logic [VPN_BITS-1:0]       tlb_vpn [TLB_ENTRIES];
    logic [PPN_BITS-1:0]       tlb_ppn [TLB_ENTRIES];

    // Holding stage for one request
    logic                      held_valid;
    logic                      faulted;
    mmu_req_t                  held_req;
    logic [REGION_BITS-1:0]    held_region;

    logic                      hit;
    logic [PPN_BITS-1:0]       hit_ppn;
    mmu_req_t                  out_req;

    logic                      in_fire;
    logic                      out_fire;

    logic                      cnfg_own;
    logic                      entry_wr;
    logic                      resolve;
    logic                      flush;

    ////////////////////////////////
    // Configuration decode
    ////////////////////////////////

    assign cnfg_own = cnfg_valid && (cnfg_region == REGION_BITS'(REGION_ID));

    // The op field picks which view of the word applies
    assign entry_wr = cnfg_own && (cnfg_word.entry.op == CNFG_ENTRY);
    assign flush    = cnfg_own && (cnfg_word.entry.op == CNFG_FLUSH);
    assign resolve  = cnfg_own && (cnfg_word.ctrl.op == CNFG_RESOLVE) && faulted;

    ////////////////////////////////
    // TLB lookup
    ////////////////////////////////

    always_comb begin
        hit     = 1'b0;
        hit_ppn = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (tlb_valid[i] && (tlb_vpn[i] == held_req.addr[VADDR_BITS-1:PAGE_BITS])) begin
                hit     = 1'b1;
                hit_ppn = tlb_ppn[i];
            end
        end
    end

    // Page offset passes straight through
    always_comb begin
        out_req      = held_req;
        out_req.addr = {hit_ppn, held_req.addr[PAGE_BITS-1:0]};
    end

    ////////////////////////////////
    // Handshakes
    ////////////////////////////////

    assign m_req.valid  = held_valid && !faulted && hit;
    assign m_req.req    = out_req;
    assign m_req.region = held_region;

    assign out_fire = m_req.valid && m_req.ready;
    assign in_fire  = s_req.valid && s_req.ready;

    // Refill in the same cycle as the output drains
    assign s_req.ready = !held_valid || out_fire;

    assign pfault_irq   = faulted;
    assign pfault_vaddr = held_req.addr;

    ////////////////////////////////
    // Control
    ////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
            faulted    <= 1'b0;
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                tlb_valid[i] <= 1'b0;
            end
        end else begin
            if (in_fire) begin
                held_valid <= 1'b1;
            end else if (out_fire) begin
                held_valid <= 1'b0;
            end else if (resolve && !cnfg_word.ctrl.retry) begin
                // Drop the faulting request
                held_valid <= 1'b0;
            end

            // Miss parks the request until software resolves it
            if (resolve) begin
                faulted <= 1'b0;
            end else if (held_valid && !faulted && !hit) begin
                faulted <= 1'b1;
            end

            for (int i = 0; i < TLB_ENTRIES; i++) begin
                if (flush) begin
                    tlb_valid[i] <= 1'b0;
                end else if (entry_wr && (cnfg_word.entry.idx == IDX_BITS'(i))) begin
                    tlb_valid[i] <= cnfg_word.entry.valid;
                end
            end
        end
    end

    ////////////////////////////////
    // Payload
    ////////////////////////////////

    always_ff @(posedge aclk) begin
        if (in_fire) begin
            held_req    <= s_req.req;
            held_region <= s_req.region;
        end
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (entry_wr && (cnfg_word.entry.idx == IDX_BITS'(i))) begin
                tlb_vpn[i] <= cnfg_word.entry.vpn;
                tlb_ppn[i] <= cnfg_word.entry.ppn;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mmu_req_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mmu_req_arbiter
    import mmu_addr_pkg::*;
#(
    parameter int N_REGIONS = 4
) (
    input  logic                         aclk,
    input  logic                         rst_n,

    mmu_req_if.sink                      s_req [N_REGIONS],

    input  logic                         dma_ready,
    output logic                         dma_valid,
    output mmu_req_t                     dma_req,
    output logic [$clog2(N_REGIONS)-1:0] dma_region
);

    localparam int REGION_BITS = $clog2(N_REGIONS);

    logic [N_REGIONS-1:0]   req_vec;
    mmu_req_t               req_pl [N_REGIONS];
    logic [REGION_BITS-1:0] req_rgn [N_REGIONS];

    logic [REGION_BITS-1:0] last_grant;
    logic [REGION_BITS-1:0] grant_idx;
    logic                   grant_any;
    logic                   stage_free;

    // Output register is empty or drains this cycle
    assign stage_free = !dma_valid || dma_ready;

    for (genvar i = 0; i < N_REGIONS; i++) begin : g_port
        assign req_vec[i] = s_req[i].valid;
        assign req_pl[i]  = s_req[i].req;
        assign req_rgn[i] = s_req[i].region;

        assign s_req[i].ready = stage_free && grant_any && (grant_idx == REGION_BITS'(i));
    end

    ////////////////////////////////
    // Round-robin pick
    ////////////////////////////////

    // Search starts just after the last winner
    always_comb begin
        logic [REGION_BITS-1:0] idx;
        grant_any = 1'b0;
        grant_idx = last_grant;
        for (int k = 1; k <= N_REGIONS; k++) begin
            idx = last_grant + REGION_BITS'(k);
            if (!grant_any && req_vec[idx]) begin
                grant_any = 1'b1;
                grant_idx = idx;
            end
        end
    end

    ////////////////////////////////
    // Output stage
    ////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            dma_valid  <= 1'b0;
            last_grant <= '1;
        end else if (stage_free) begin
            dma_valid <= grant_any;
            if (grant_any) begin
                last_grant <= grant_idx;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (stage_free && grant_any) begin
            dma_req    <= req_pl[grant_idx];
            dma_region <= req_rgn[grant_idx];
        end
    end

endmodule

`default_nettype wire

/* hw/mmu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mmu_top
    import mmu_addr_pkg::*;
    import mmu_cnfg_pkg::*;
#(
    parameter int N_REGIONS   = 4,
    parameter int TLB_ENTRIES = 8
) (
    input  logic                                   aclk,
    input  logic                                   rst_n,

    // Incoming requests
    input  logic                                   req_valid,
    output logic                                   req_ready,
    input  logic [$clog2(N_REGIONS)-1:0]           req_region,
    input  logic [VADDR_BITS-1:0]                  req_vaddr,
    input  logic [LEN_BITS-1:0]                    req_len,
    input  logic                                   req_wr,

    // Configuration strobe
    input  logic                                   cnfg_valid,
    input  logic [$clog2(N_REGIONS)-1:0]           cnfg_region,
    input  cnfg_word_u                             cnfg_word,

    // DMA request port
    output logic                                   dma_valid,
    input  logic                                   dma_ready,
    output logic [PADDR_BITS-1:0]                  dma_paddr,
    output logic [LEN_BITS-1:0]                    dma_len,
    output logic                                   dma_wr,
    output logic [$clog2(N_REGIONS)-1:0]           dma_region,

    // Page faults
    output logic [N_REGIONS-1:0]                   pfault_irq,
    output logic [N_REGIONS-1:0][VADDR_BITS-1:0]   pfault_vaddr
);

    mmu_req_t in_req;
    mmu_req_t dma_req;

    assign in_req.addr = req_vaddr;
    assign in_req.len  = req_len;
    assign in_req.wr   = req_wr;

    assign dma_paddr = dma_req.addr;
    assign dma_len   = dma_req.len;
    assign dma_wr    = dma_req.wr;

    mmu_req_if #(.N_REGIONS(N_REGIONS)) disp_if [N_REGIONS] ();
    mmu_req_if #(.N_REGIONS(N_REGIONS)) arb_if  [N_REGIONS] ();

    //////////////////////////////
    // Dispatch
    //////////////////////////////

    mmu_req_dispatch #(
        .N_REGIONS (N_REGIONS)
    ) mmu_req_dispatch_inst (
        .req_valid  (req_valid),
        .req        (in_req),
        .req_region (req_region),
        .req_ready  (req_ready),
        .reg_out    (disp_if)
    );

    //////////////////////////////
    // Region MMUs
    //////////////////////////////

    for (genvar i = 0; i < N_REGIONS; i++) begin : g_region
        mmu_region #(
            .N_REGIONS   (N_REGIONS),
            .REGION_ID   (i),
            .TLB_ENTRIES (TLB_ENTRIES)
        ) mmu_region_inst (
            .aclk         (aclk),
            .rst_n        (rst_n),
            .cnfg_valid   (cnfg_valid),
            .cnfg_region  (cnfg_region),
            .cnfg_word    (cnfg_word),
            .s_req        (disp_if[i]),
            .m_req        (arb_if[i]),
            .pfault_irq   (pfault_irq[i]),
            .pfault_vaddr (pfault_vaddr[i])
        );
    end

    //////////////////////////////
    // Merge onto the DMA port
    //////////////////////////////

    mmu_req_arbiter #(
        .N_REGIONS (N_REGIONS)
    ) mmu_req_arbiter_inst (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .s_req      (arb_if),
        .dma_ready  (dma_ready),
        .dma_valid  (dma_valid),
        .dma_req    (dma_req),
        .dma_region (dma_region)
    );

endmodule

`default_nettype wire

/* testbench/mmu_top_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mmu_top_tb
    import mmu_addr_pkg::*;
    import mmu_cnfg_pkg::*;
();

    localparam int N_REGIONS   = 4;
    localparam int TLB_ENTRIES = 8;
    localparam int TIMEOUT     = 2000;

    logic                                 aclk;
    logic                                 rst_n;
    logic                                 req_valid;
    logic                                 req_ready;
    logic [1:0]                           req_region;
    logic [VADDR_BITS-1:0]                req_vaddr;
    logic [LEN_BITS-1:0]                  req_len;
    logic                                 req_wr;
    logic                                 cnfg_valid;
    logic [1:0]                           cnfg_region;
    cnfg_word_u                           cnfg_word;
    logic                                 dma_valid;
    logic                                 dma_ready;
    logic [PADDR_BITS-1:0]                dma_paddr;
    logic [LEN_BITS-1:0]                  dma_len;
    logic                                 dma_wr;
    logic [1:0]                           dma_region;
    logic [N_REGIONS-1:0]                 pfault_irq;
    logic [N_REGIONS-1:0][VADDR_BITS-1:0] pfault_vaddr;

    // Shadow TLB and expected outputs per region
    logic          sh_valid [N_REGIONS][TLB_ENTRIES];
    logic [19:0]   sh_vpn [N_REGIONS][TLB_ENTRIES];
    logic [19:0]   sh_ppn [N_REGIONS][TLB_ENTRIES];
    mmu_req_t      exp_q [N_REGIONS][$];

    logic [31:0]   stim_state;
    logic [31:0]   bp_state;
    logic          bp_en;
    int            err_count;
    int            check_count;
    int            push_count;
    int            recv_count;

    mmu_top #(
        .N_REGIONS   (N_REGIONS),
        .TLB_ENTRIES (TLB_ENTRIES)
    ) mmu_top_inst (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_region   (req_region),
        .req_vaddr    (req_vaddr),
        .req_len      (req_len),
        .req_wr       (req_wr),
        .cnfg_valid   (cnfg_valid),
        .cnfg_region  (cnfg_region),
        .cnfg_word    (cnfg_word),
        .dma_valid    (dma_valid),
        .dma_ready    (dma_ready),
        .dma_paddr    (dma_paddr),
        .dma_len      (dma_len),
        .dma_wr       (dma_wr),
        .dma_region   (dma_region),
        .pfault_irq   (pfault_irq),
        .pfault_vaddr (pfault_vaddr)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] draw(inout logic [31:0] state, input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], fb};
            val   = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] translate(input int rgn, input logic [31:0] vaddr);
        logic [31:0] paddr;
        paddr = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (sh_valid[rgn][i] && sh_vpn[rgn][i] == vaddr[31:12]) begin
                paddr = {sh_ppn[rgn][i], vaddr[11:0]};
            end
        end
        return paddr;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        check_count++;
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s at %0t", what, $time);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic step();
        @(posedge aclk);
        #1;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("Test %0d (%s): %s", num, name, (err_count == errs_before) ? "passed" : "failed");
    endtask

    //////////////////////////////
    // Configuration port
    //////////////////////////////

    task automatic send_cnfg(input int rgn, input cnfg_word_u w);
        cnfg_valid  = 1'b1;
        cnfg_region = 2'(rgn);
        cnfg_word   = w;
        step();
        cnfg_valid = 1'b0;
    endtask

    task automatic write_entry(input int rgn, input int idx, input logic [19:0] vpn,
                               input logic [19:0] ppn);
        cnfg_word_u w;
        w             = '0;
        w.entry.op    = CNFG_ENTRY;
        w.entry.idx   = 4'(idx);
        w.entry.valid = 1'b1;
        w.entry.vpn   = vpn;
        w.entry.ppn   = ppn;
        sh_valid[rgn][idx] = 1'b1;
        sh_vpn[rgn][idx]   = vpn;
        sh_ppn[rgn][idx]   = ppn;
        send_cnfg(rgn, w);
    endtask

    task automatic resolve_fault(input int rgn, input logic retry);
        cnfg_word_u w;
        w            = '0;
        w.ctrl.op    = CNFG_RESOLVE;
        w.ctrl.retry = retry;
        send_cnfg(rgn, w);
    endtask

    task automatic flush_region(input int rgn);
        cnfg_word_u w;
        w         = '0;
        w.ctrl.op = CNFG_FLUSH;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            sh_valid[rgn][i] = 1'b0;
        end
        send_cnfg(rgn, w);
    endtask

    //////////////////////////////
    // Request port and waits
    //////////////////////////////

    task automatic issue_req(input int rgn, input logic [31:0] vaddr, input logic [15:0] len,
                             input logic wr, input bit mapped);
        int       cycles;
        mmu_req_t exp;
        req_valid  = 1'b1;
        req_region = 2'(rgn);
        req_vaddr  = vaddr;
        req_len    = len;
        req_wr     = wr;
        cycles     = 0;
        @(negedge aclk);
        while (!req_ready) begin
            cycles++;
            if (cycles > TIMEOUT) abort_run("request never accepted");
            @(negedge aclk);
        end
        // Accepted on the coming edge
        if (mapped) begin
            exp.addr = translate(rgn, vaddr);
            exp.len  = len;
            exp.wr   = wr;
            exp_q[rgn].push_back(exp);
            push_count++;
        end
        step();
        req_valid = 1'b0;
    endtask

    task automatic send_random();
        int          rgn;
        int          idx;
        logic [31:0] vaddr;
        rgn   = draw(stim_state, 2);
        idx   = draw(stim_state, 3);
        vaddr = {sh_vpn[rgn][idx], 12'(draw(stim_state, 12))};
        issue_req(rgn, vaddr, draw(stim_state, 16), draw(stim_state, 1), 1'b1);
    endtask

    task automatic wait_irq(input int rgn, input logic level);
        int cycles;
        cycles = 0;
        @(negedge aclk);
        while (pfault_irq[rgn] !== level) begin
            cycles++;
            if (cycles > TIMEOUT) abort_run("page fault interrupt never changed");
            @(negedge aclk);
        end
        step();
    endtask

    task automatic wait_drain();
        int cycles;
        int pending;
        cycles = 0;
        forever begin
            @(negedge aclk);
            pending = 0;
            for (int r = 0; r < N_REGIONS; r++) begin
                pending += exp_q[r].size();
            end
            if (pending == 0) break;
            cycles++;
            if (cycles > TIMEOUT) abort_run("expected DMA requests never arrived");
        end
        step();
    endtask

    //////////////////////////////
    // DMA monitor and back-pressure
    //////////////////////////////

    always @(negedge aclk) begin
        mmu_req_t exp;
        if (rst_n && dma_valid && dma_ready) begin
            recv_count++;
            if (exp_q[dma_region].size() == 0) begin
                $display("Unexpected DMA request from region %0d at %0t", dma_region, $time);
                err_count++;
            end else begin
                exp = exp_q[dma_region].pop_front();
                check_val("dma_paddr", exp.addr, dma_paddr);
                check_val("dma_len", exp.len, dma_len);
                check_val("dma_wr", exp.wr, dma_wr);
            end
        end
    end

    always @(posedge aclk) begin
        #1;
        if (bp_en) begin
            dma_ready = |draw(bp_state, 2);
        end else begin
            dma_ready = 1'b1;
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int          rgn;
        int          other;
        int          errs_before;
        logic [31:0] vaddr;
        mmu_req_t    exp_req;

        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_region  = '0;
        req_vaddr   = '0;
        req_len     = '0;
        req_wr      = 1'b0;
        cnfg_valid  = 1'b0;
        cnfg_region = '0;
        cnfg_word   = '0;
        dma_ready   = 1'b1;
        bp_en       = 1'b0;
        stim_state  = 32'h4d19dee5;
        bp_state    = 32'h4d19dee5;
        err_count   = 0;
        check_count = 0;
        push_count  = 0;
        recv_count  = 0;

        repeat (2) @(posedge aclk);
        #1;
        rst_n = 1'b1;

        errs_before = err_count;
        @(negedge aclk);
        check_val("dma_valid", 1'b0, dma_valid);
        check_val("pfault_irq", '0, pfault_irq);
        check_val("req_ready", 1'b1, req_ready);
        step();
        report_test(1, "reset state", errs_before);

        // Low vpn nibble equals the index, so vpns never collide
        errs_before = err_count;
        for (int r = 0; r < N_REGIONS; r++) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                write_entry(r, i, {16'(draw(stim_state, 16)), 4'(i)}, draw(stim_state, 20));
            end
        end
        for (int n = 0; n < 40; n++) begin
            send_random();
            if (draw(stim_state, 2) == 0) step();
        end
        wait_drain();
        report_test(2, "mapped translation", errs_before);

        errs_before = err_count;
        bp_en = 1'b1;
        for (int n = 0; n < 200; n++) begin
            send_random();
        end
        wait_drain();
        bp_en = 1'b0;
        check_val("dma transfer count", push_count, recv_count);
        report_test(3, "back-pressure", errs_before);

        // Nibble F is never an index, so the page is unmapped
        errs_before = err_count;
        rgn   = draw(stim_state, 2);
        vaddr = {16'(draw(stim_state, 16)), 4'hf, 12'(draw(stim_state, 12))};
        issue_req(rgn, vaddr, 16'h0040, 1'b0, 1'b0);
        wait_irq(rgn, 1'b1);
        check_val("pfault_vaddr", vaddr, pfault_vaddr[rgn]);
        write_entry(rgn, 7, vaddr[31:12], draw(stim_state, 20));
        exp_req.addr = translate(rgn, vaddr);
        exp_req.len  = 16'h0040;
        exp_req.wr   = 1'b0;
        exp_q[rgn].push_back(exp_req);
        push_count++;
        resolve_fault(rgn, 1'b1);
        wait_irq(rgn, 1'b0);
        wait_drain();
        report_test(4, "fault and retry", errs_before);

        errs_before = err_count;
        rgn   = draw(stim_state, 2);
        vaddr = {16'(draw(stim_state, 16)), 4'he, 12'(draw(stim_state, 12))};
        issue_req(rgn, vaddr, 16'h0100, 1'b1, 1'b0);
        wait_irq(rgn, 1'b1);
        check_val("pfault_vaddr", vaddr, pfault_vaddr[rgn]);
        resolve_fault(rgn, 1'b0);
        wait_irq(rgn, 1'b0);
        vaddr = {sh_vpn[rgn][2], 12'(draw(stim_state, 12))};
        issue_req(rgn, vaddr, 16'h0020, 1'b1, 1'b1);
        wait_drain();
        check_val("dma transfer count", push_count, recv_count);
        report_test(5, "fault and drop", errs_before);

        errs_before = err_count;
        rgn   = draw(stim_state, 2);
        other = (rgn + 1) % N_REGIONS;
        vaddr = {sh_vpn[rgn][3], 12'(draw(stim_state, 12))};
        flush_region(rgn);
        issue_req(rgn, vaddr, 16'h0008, 1'b0, 1'b0);
        wait_irq(rgn, 1'b1);
        check_val("pfault_vaddr", vaddr, pfault_vaddr[rgn]);
        vaddr = {sh_vpn[other][3], 12'(draw(stim_state, 12))};
        issue_req(other, vaddr, 16'h0008, 1'b0, 1'b1);
        wait_drain();
        resolve_fault(rgn, 1'b0);
        wait_irq(rgn, 1'b0);
        report_test(6, "flush", errs_before);

        $display("Checks: %0d, errors: %0d, requests sent: %0d, received: %0d",
                 check_count, err_count, push_count, recv_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hw/mmu_addr_pkg.sv
hw/mmu_cnfg_pkg.sv
hw/mmu_req_if.sv
hw/mmu_req_dispatch.sv
hw/mmu_region.sv
hw/mmu_req_arbiter.sv
hw/mmu_top.sv
testbench/mmu_top_tb.sv
